/* bus_ctrl_pkg.sv */
/*
 * Board-control register map: addresses, field widths, reset values
 */
`default_nettype none

package bus_ctrl_pkg;

   // ------------------------------------------------------------------
   // Bus widths
   // ------------------------------------------------------------------
   // Settings and readback share one address width
   localparam int SR_AWIDTH = 8;
   localparam int DATA_W    = 32;

   // ------------------------------------------------------------------
   // Settings (write) addresses
   // ------------------------------------------------------------------
   localparam logic [SR_AWIDTH-1:0] SR_LEDS       = 8'd0;
   localparam logic [SR_AWIDTH-1:0] SR_SW_RST     = 8'd1;
   localparam logic [SR_AWIDTH-1:0] SR_CLOCK_CTRL = 8'd2;
   // Rate select for each SFP+ cage
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL0 = 8'd8;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL1 = 8'd9;
   // Any write here clears the sticky FIFO flags
   localparam logic [SR_AWIDTH-1:0] SR_FIFOFLAGS  = 8'd10;

   // ------------------------------------------------------------------
   // Readback addresses
   // ------------------------------------------------------------------
   localparam logic [SR_AWIDTH-1:0] RB_COUNTER      = 8'd0;
   localparam logic [SR_AWIDTH-1:0] RB_CLK_STATUS   = 8'd3;
   localparam logic [SR_AWIDTH-1:0] RB_COMPAT_NUM   = 8'd6;
   // Reading a cage status word clears its changed bits
   localparam logic [SR_AWIDTH-1:0] RB_SFPP_STATUS0 = 8'd8;
   localparam logic [SR_AWIDTH-1:0] RB_SFPP_STATUS1 = 8'd9;
   localparam logic [SR_AWIDTH-1:0] RB_FIFOFLAGS    = 8'd10;

   // Field widths
   localparam int LEDS_W         = 8;
   localparam int SW_RST_W       = 4;
   localparam int CLOCK_CTRL_W   = 7;
   localparam int SFPP_CTRL_W    = 2;
   localparam int CLOCK_STATUS_W = 5;
   localparam int PHY_STATUS_W   = 16;

   // Reset values
   localparam logic [LEDS_W-1:0]      LEDS_RESET       = '0;
   localparam logic [SW_RST_W-1:0]    SW_RST_RESET     = '0;
   // Bit 6 keeps the disciplined oscillator on out of reset
   localparam logic [CLOCK_CTRL_W-1:0] CLOCK_CTRL_RESET = 7'b100_0000;
   // Pads released, no rate-select pull-down
   localparam logic [SFPP_CTRL_W-1:0] SFPP_CTRL_RESET  = '0;

   // Compatibility number, major in the upper half
   localparam logic [15:0] COMPAT_MAJOR = 16'd10;
   localparam logic [15:0] COMPAT_MINOR = 16'd0;

endpackage

`default_nettype wire

/* bus_ctrl_top.sv */
/*
 * Board-control register block for the bus clock domain
 */
`timescale 1ns/100ps
`default_nettype none

module bus_ctrl_top #(
   parameter int NUM_FIFO_FLAGS = 4
) (
   input  wire                                     clk,
   input  wire                                     reset,
   // Host port
   input  wire                                     i_req,
   input  wire                                     i_we,
   input  wire [bus_ctrl_pkg::SR_AWIDTH-1:0]       i_addr,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]          i_wdata,
   output logic                                    o_ack,
   output logic [bus_ctrl_pkg::DATA_W-1:0]         o_rdata,
   // SFP+ cage 0
   input  wire                                     i_sfpp0_mod_abs,
   input  wire                                     i_sfpp0_tx_fault,
   input  wire                                     i_sfpp0_rx_los,
   input  wire [bus_ctrl_pkg::PHY_STATUS_W-1:0]    i_eth0_phy_status,
   // SFP+ cage 1
   input  wire                                     i_sfpp1_mod_abs,
   input  wire                                     i_sfpp1_tx_fault,
   input  wire                                     i_sfpp1_rx_los,
   input  wire [bus_ctrl_pkg::PHY_STATUS_W-1:0]    i_eth1_phy_status,
   // Board status and control
   input  wire [bus_ctrl_pkg::CLOCK_STATUS_W-1:0]  i_clock_status,
   input  wire [NUM_FIFO_FLAGS-1:0]                i_fifo_flags,
   output logic [bus_ctrl_pkg::LEDS_W-1:0]         o_leds,
   output logic [bus_ctrl_pkg::SW_RST_W-1:0]       o_sw_rst,
   output logic [bus_ctrl_pkg::CLOCK_CTRL_W-1:0]   o_clock_control,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]    o_sfpp0_rs_oe,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]    o_sfpp1_rs_oe
);

   // Settings and readback buses
   logic                               set_stb;
   logic [bus_ctrl_pkg::SR_AWIDTH-1:0] set_addr;
   logic [bus_ctrl_pkg::DATA_W-1:0]    set_data;
   logic [bus_ctrl_pkg::SR_AWIDTH-1:0] rb_addr;
   logic                               rb_rd_stb;
   logic [bus_ctrl_pkg::DATA_W-1:0]    rb_data;
   // Status words and clears
   logic [bus_ctrl_pkg::DATA_W-1:0]    sfpp0_status;
   logic [bus_ctrl_pkg::DATA_W-1:0]    sfpp1_status;
   logic [bus_ctrl_pkg::DATA_W-1:0]    fifo_flags_word;
   logic                               fifo_clear;
   logic                               clr0;
   logic                               clr1;

   host_port host_port0 (
      .clk(clk), .reset(reset),
      .i_req(i_req), .i_we(i_we), .i_addr(i_addr), .i_wdata(i_wdata),
      .o_ack(o_ack), .o_rdata(o_rdata),
      .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
      .o_rb_addr(rb_addr), .o_rb_rd_stb(rb_rd_stb), .i_rb_data(rb_data)
   );

   setting_bank setting_bank0 (
      .clk(clk), .reset(reset),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_sfpp0_rs_oe(o_sfpp0_rs_oe), .o_sfpp1_rs_oe(o_sfpp1_rs_oe),
      .o_fifo_clear(fifo_clear)
   );

   // One monitor per cage
   sfp_status_mon sfp_mon0 (
      .clk(clk), .reset(reset),
      .i_mod_abs(i_sfpp0_mod_abs), .i_tx_fault(i_sfpp0_tx_fault),
      .i_rx_los(i_sfpp0_rx_los), .i_phy_status(i_eth0_phy_status),
      .i_clr(clr0), .o_status(sfpp0_status)
   );

   sfp_status_mon sfp_mon1 (
      .clk(clk), .reset(reset),
      .i_mod_abs(i_sfpp1_mod_abs), .i_tx_fault(i_sfpp1_tx_fault),
      .i_rx_los(i_sfpp1_rx_los), .i_phy_status(i_eth1_phy_status),
      .i_clr(clr1), .o_status(sfpp1_status)
   );

   fifo_flag_monitor #(.NUM_FLAGS(NUM_FIFO_FLAGS)) fifo_mon0 (
      .clk(clk), .reset(reset),
      .i_fifo_flags(i_fifo_flags), .i_clear(fifo_clear), .o_flags(fifo_flags_word)
   );

   readback_mux readback_mux0 (
      .clk(clk), .reset(reset),
      .i_rb_addr(rb_addr), .i_rb_rd_stb(rb_rd_stb),
      .i_clock_status(i_clock_status),
      .i_sfpp0_status(sfpp0_status), .i_sfpp1_status(sfpp1_status),
      .i_fifo_flags(fifo_flags_word),
      .o_rb_data(rb_data), .o_clr0(clr0), .o_clr1(clr1)
   );

endmodule

`default_nettype wire

/* fifo_flag_monitor.sv */
/*
 * Sticky capture of active-low FIFO fault flags
 */
`timescale 1ns/100ps
`default_nettype none

module fifo_flag_monitor #(
   parameter int NUM_FLAGS = 4
) (
   input  wire                             clk,
   input  wire                             reset,
   input  wire [NUM_FLAGS-1:0]             i_fifo_flags,
   // One-cycle clear from the settings bank
   input  wire                             i_clear,
   output logic [bus_ctrl_pkg::DATA_W-1:0] o_flags
);

   logic [NUM_FLAGS-1:0] flags_q;

   // A flag seen low once stays set until cleared
   always_ff @(posedge clk) begin
      if (reset || i_clear)
         flags_q <= '0;
      else
         flags_q <= flags_q | ~i_fifo_flags;
   end

   // Zero-extend into the readback word
   always_comb begin
      o_flags                  = '0;
      o_flags[NUM_FLAGS-1:0]   = flags_q;
   end

endmodule

`default_nettype wire

/* host_port.sv */
/*
 * Host port: four-phase req/ack handshake turned into one settings
 * write strobe or one readback strobe per request
 */
`timescale 1ns/100ps
`default_nettype none

module host_port (
   input  wire                                clk,
   input  wire                                reset,
   // Host side
   input  wire                                i_req,
   input  wire                                i_we,
   input  wire [bus_ctrl_pkg::SR_AWIDTH-1:0]  i_addr,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]     i_wdata,
   output logic                               o_ack,
   output logic [bus_ctrl_pkg::DATA_W-1:0]    o_rdata,
   // Settings bus
   output logic                               o_set_stb,
   output logic [bus_ctrl_pkg::SR_AWIDTH-1:0] o_set_addr,
   output logic [bus_ctrl_pkg::DATA_W-1:0]    o_set_data,
   // Readback bus
   output logic [bus_ctrl_pkg::SR_AWIDTH-1:0] o_rb_addr,
   output logic                               o_rb_rd_stb,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]     i_rb_data
);

   // Handshake states
   localparam logic [1:0] S_IDLE     = 2'd0;
   localparam logic [1:0] S_STROBE   = 2'd1;
   localparam logic [1:0] S_ACK      = 2'd2;
   localparam logic [1:0] S_WAIT_REL = 2'd3;

   logic [1:0]                         state;
   // Request held from acceptance until the next one
   logic                               we_q;
   logic [bus_ctrl_pkg::SR_AWIDTH-1:0] addr_q;
   logic [bus_ctrl_pkg::DATA_W-1:0]    data_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE:     if (i_req) state <= S_STROBE;
            // Exactly one strobe cycle per request
            S_STROBE:   state <= S_ACK;
            // Host may already have dropped req in the first ack cycle
            S_ACK:      state <= i_req ? S_WAIT_REL : S_IDLE;
            S_WAIT_REL: if (!i_req) state <= S_IDLE;
            default:    state <= S_IDLE;
         endcase
      end
   end

   // Latch the request as it is accepted
   always_ff @(posedge clk) begin
      if (state == S_IDLE && i_req) begin
         we_q   <= i_we;
         addr_q <= i_addr;
         data_q <= i_wdata;
      end
   end

   // Read data taken in the strobe cycle, before any read-clear lands
   always_ff @(posedge clk) begin
      if (state == S_STROBE && !we_q)
         o_rdata <= i_rb_data;
   end

   assign o_ack       = (state == S_ACK) || (state == S_WAIT_REL);
   assign o_set_stb   = (state == S_STROBE) && we_q;
   assign o_rb_rd_stb = (state == S_STROBE) && !we_q;
   assign o_set_addr  = addr_q;
   assign o_set_data  = data_q;
   assign o_rb_addr   = addr_q;

endmodule

`default_nettype wire

/* readback_mux.sv */
/*
 * Readback: free-running cycle counter, address decode of the
 * readback word and per-cage read-clear pulses
 */
`timescale 1ns/100ps
`default_nettype none

module readback_mux (
   input  wire                                     clk,
   input  wire                                     reset,
   // Readback bus
   input  wire [bus_ctrl_pkg::SR_AWIDTH-1:0]       i_rb_addr,
   input  wire                                     i_rb_rd_stb,
   // Status sources
   input  wire [bus_ctrl_pkg::CLOCK_STATUS_W-1:0]  i_clock_status,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]          i_sfpp0_status,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]          i_sfpp1_status,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]          i_fifo_flags,
   output logic [bus_ctrl_pkg::DATA_W-1:0]         o_rb_data,
   // Read-clear to each cage monitor
   output logic                                    o_clr0,
   output logic                                    o_clr1
);

   logic [bus_ctrl_pkg::DATA_W-1:0] counter;

   // ------------------------------------------------------------------
   // Cycle counter
   // ------------------------------------------------------------------
   // Wraps silently
   always_ff @(posedge clk) begin
      if (reset)
         counter <= '0;
      else
         counter <= counter + 1'b1;
   end

   // ------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------
   always_comb begin
      // Unknown addresses read zero
      o_rb_data = '0;
      case (i_rb_addr)
         bus_ctrl_pkg::RB_COUNTER:
            o_rb_data = counter;
         bus_ctrl_pkg::RB_CLK_STATUS:
            o_rb_data[bus_ctrl_pkg::CLOCK_STATUS_W-1:0] = i_clock_status;
         bus_ctrl_pkg::RB_COMPAT_NUM:
            o_rb_data = {bus_ctrl_pkg::COMPAT_MAJOR, bus_ctrl_pkg::COMPAT_MINOR};
         bus_ctrl_pkg::RB_SFPP_STATUS0:
            o_rb_data = i_sfpp0_status;
         bus_ctrl_pkg::RB_SFPP_STATUS1:
            o_rb_data = i_sfpp1_status;
         bus_ctrl_pkg::RB_FIFOFLAGS:
            o_rb_data = i_fifo_flags;
         default:
            o_rb_data = '0;
      endcase
   end

   // Clear only the cage actually being read
   assign o_clr0 = i_rb_rd_stb && (i_rb_addr == bus_ctrl_pkg::RB_SFPP_STATUS0);
   assign o_clr1 = i_rb_rd_stb && (i_rb_addr == bus_ctrl_pkg::RB_SFPP_STATUS1);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the board-control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_bus_ctrl -o sim_bus_ctrl

# A failing run is caught by the log search below
./obj_dir/sim_bus_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation finished without failure"

/* setting_bank.sv */
/*
 * Settings bank: write-decoded board control registers
 * and the FIFO-flag clear pulse
 */
`timescale 1ns/100ps
`default_nettype none

module setting_bank (
   input  wire                                   clk,
   input  wire                                   reset,
   // Settings bus
   input  wire                                   i_set_stb,
   input  wire [bus_ctrl_pkg::SR_AWIDTH-1:0]     i_set_addr,
   input  wire [bus_ctrl_pkg::DATA_W-1:0]        i_set_data,
   // Control outputs
   output logic [bus_ctrl_pkg::LEDS_W-1:0]       o_leds,
   output logic [bus_ctrl_pkg::SW_RST_W-1:0]     o_sw_rst,
   output logic [bus_ctrl_pkg::CLOCK_CTRL_W-1:0] o_clock_control,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]  o_sfpp0_rs_oe,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]  o_sfpp1_rs_oe,
   output logic                                  o_fifo_clear
);

   // ------------------------------------------------------------------
   // Register decode
   // ------------------------------------------------------------------
   // SW_RST bits
   //   [0] PHY reset
   //   [1] radio clock domain reset
   //   [2] radio clock PLL reset
   //   [3] spare
   // SFPP_CTRL bits drive open-drain rate selects RS0 and RS1,
   // a set bit pulls the pad low
   always_ff @(posedge clk) begin
      if (reset) begin
         o_leds          <= bus_ctrl_pkg::LEDS_RESET;
         o_sw_rst        <= bus_ctrl_pkg::SW_RST_RESET;
         o_clock_control <= bus_ctrl_pkg::CLOCK_CTRL_RESET;
         o_sfpp0_rs_oe   <= bus_ctrl_pkg::SFPP_CTRL_RESET;
         o_sfpp1_rs_oe   <= bus_ctrl_pkg::SFPP_CTRL_RESET;
      end else if (i_set_stb) begin
         case (i_set_addr)
            bus_ctrl_pkg::SR_LEDS: begin
               o_leds <= i_set_data[bus_ctrl_pkg::LEDS_W-1:0];
            end
            bus_ctrl_pkg::SR_SW_RST: begin
               o_sw_rst <= i_set_data[bus_ctrl_pkg::SW_RST_W-1:0];
            end
            bus_ctrl_pkg::SR_CLOCK_CTRL: begin
               o_clock_control <= i_set_data[bus_ctrl_pkg::CLOCK_CTRL_W-1:0];
            end
            bus_ctrl_pkg::SR_SFPP_CTRL0: begin
               o_sfpp0_rs_oe <= i_set_data[bus_ctrl_pkg::SFPP_CTRL_W-1:0];
            end
            bus_ctrl_pkg::SR_SFPP_CTRL1: begin
               o_sfpp1_rs_oe <= i_set_data[bus_ctrl_pkg::SFPP_CTRL_W-1:0];
            end
            // Unmapped addresses and SR_FIFOFLAGS leave registers alone
            default: begin
            end
         endcase
      end
   end

   // ------------------------------------------------------------------
   // FIFO flag clear
   // ------------------------------------------------------------------
   // Data ignored, the write itself is the command
   // Pulse lines up with the strobe so the clear lands at the same edge
   assign o_fifo_clear = i_set_stb && (i_set_addr == bus_ctrl_pkg::SR_FIFOFLAGS);

endmodule

`default_nettype wire

/* sfp_status_mon.sv */
/*
 * SFP+ cage monitor: synchronizes module pins and PHY status,
 * latches pin changes until the status word is read
 */
`timescale 1ns/100ps
`default_nettype none

module sfp_status_mon (
   input  wire                                   clk,
   input  wire                                   reset,
   // Asynchronous cage pins
   input  wire                                   i_mod_abs,
   input  wire                                   i_tx_fault,
   input  wire                                   i_rx_los,
   input  wire [bus_ctrl_pkg::PHY_STATUS_W-1:0]  i_phy_status,
   // Read of this cage's status word
   input  wire                                   i_clr,
   output logic [bus_ctrl_pkg::DATA_W-1:0]       o_status
);

   // Module pins in status order, mod_abs highest
   localparam int NUM_PINS = 3;
   localparam int SYNC_W   = bus_ctrl_pkg::PHY_STATUS_W + NUM_PINS;
   // Unused middle of the status word
   localparam int PAD_W    = bus_ctrl_pkg::DATA_W - bus_ctrl_pkg::PHY_STATUS_W - 2 * NUM_PINS;

   logic [SYNC_W-1:0]                    sync_meta;
   logic [SYNC_W-1:0]                    sync_out;
   logic [bus_ctrl_pkg::PHY_STATUS_W-1:0] phy_sync;
   logic [NUM_PINS-1:0]                  pin_sync;
   logic [NUM_PINS-1:0]                  pin_hist;
   logic [NUM_PINS-1:0]                  pin_chgd;

   // ------------------------------------------------------------------
   // Two-flop synchronizer
   // ------------------------------------------------------------------
   // All 19 bits treated as independent asynchronous signals
   always_ff @(posedge clk) begin
      if (reset) begin
         sync_meta <= '0;
         sync_out  <= '0;
      end else begin
         sync_meta <= {i_phy_status, i_mod_abs, i_tx_fault, i_rx_los};
         sync_out  <= sync_meta;
      end
   end

   assign phy_sync = sync_out[SYNC_W-1:NUM_PINS];
   assign pin_sync = sync_out[NUM_PINS-1:0];

   // ------------------------------------------------------------------
   // Change detect
   // ------------------------------------------------------------------
   // One cycle of history per module pin
   always_ff @(posedge clk) begin
      if (reset)
         pin_hist <= '0;
      else
         pin_hist <= pin_sync;
   end

   // Sticky until read, read clear wins over a coincident change
   always_ff @(posedge clk) begin
      if (reset || i_clr)
         pin_chgd <= '0;
      else
         pin_chgd <= pin_chgd | (pin_sync ^ pin_hist);
   end

   // PHY status, pad, changed bits, live pins
   assign o_status = {phy_sync, {PAD_W{1'b0}}, pin_chgd, pin_sync};

endmodule

`default_nettype wire

/* tb_bus_ctrl.sv */
/*
 * Testbench for the board-control register block: host driver,
 * register and pin model, read checker and watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tb_bus_ctrl;

   localparam int CLK_PERIOD    = 40;
   localparam int RESET_CYCLES  = 16;
   localparam int NUM_FLAGS     = 4;
   // Test lengths in rounds
   localparam int WRITE_OPS     = 60;
   localparam int COUNTER_PAIRS = 15;
   localparam int CLK_ROUNDS    = 10;
   localparam int SFP_ROUNDS    = 12;
   localparam int FIFO_ROUNDS   = 8;
   // Worst case handshake with slow-host hold, and pin settle time
   localparam int OP_CYCLES     = 12;
   localparam int SETTLE_CYCLES = 10;
   localparam int TOTAL_OPS     = 9 + WRITE_OPS * 2 + COUNTER_PAIRS * 2 + CLK_ROUNDS
                                  + SFP_ROUNDS * 3 + FIFO_ROUNDS * 3;
   localparam int TOTAL_CYCLES  = RESET_CYCLES + OP_CYCLES * TOTAL_OPS
                                  + SETTLE_CYCLES * (SFP_ROUNDS + FIFO_ROUNDS);
   localparam int MARGIN        = 4;

   logic                 clk;
   logic                 reset;
   logic                 req;
   logic                 we;
   logic [7:0]           addr;
   logic [31:0]          wdata;
   wire                  ack;
   wire  [31:0]          rdata;
   // Cage pins ordered mod_abs tx_fault rx_los from high to low
   logic [2:0]           pins [2];
   logic [15:0]          phy [2];
   logic [4:0]           clk_status;
   logic [NUM_FLAGS-1:0] fifo_flags;
   wire  [7:0]           leds;
   wire  [3:0]           sw_rst;
   wire  [6:0]           clock_control;
   wire  [1:0]           rs_oe0;
   wire  [1:0]           rs_oe1;

   // Model of registers and sticky bits
   logic [7:0]           m_leds = 8'd0;
   logic [3:0]           m_sw_rst = 4'd0;
   logic [6:0]           m_clock_control = 7'b100_0000;
   logic [1:0]           m_rs_oe0 = 2'd0;
   logic [1:0]           m_rs_oe1 = 2'd0;
   logic [2:0]           m_chgd [2];
   logic [NUM_FLAGS-1:0] m_fifo_sticky = '0;

   // Read hand-over to the checker
   logic [7:0]           rd_addr;
   logic [31:0]          rd_data;
   logic [31:0]          last_counter = 32'd0;
   int                   reads_issued = 0;
   int                   reads_checked = 0;
   int                   ack_rises = 0;
   int                   error_count = 0;

   bus_ctrl_top #(.NUM_FIFO_FLAGS(NUM_FLAGS)) dut0 (
      .clk(clk), .reset(reset),
      .i_req(req), .i_we(we), .i_addr(addr), .i_wdata(wdata),
      .o_ack(ack), .o_rdata(rdata),
      .i_sfpp0_mod_abs(pins[0][2]), .i_sfpp0_tx_fault(pins[0][1]),
      .i_sfpp0_rx_los(pins[0][0]), .i_eth0_phy_status(phy[0]),
      .i_sfpp1_mod_abs(pins[1][2]), .i_sfpp1_tx_fault(pins[1][1]),
      .i_sfpp1_rx_los(pins[1][0]), .i_eth1_phy_status(phy[1]),
      .i_clock_status(clk_status), .i_fifo_flags(fifo_flags),
      .o_leds(leds), .o_sw_rst(sw_rst), .o_clock_control(clock_control),
      .o_sfpp0_rs_oe(rs_oe0), .o_sfpp1_rs_oe(rs_oe1)
   );

   initial begin : clock_gen
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge ack) ack_rises = ack_rises + 1;

   task automatic stop_with_error(input string msg);
      error_count = error_count + 1;
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1);
   endtask

   // ------------------------------------------------------------------
   // Reference model of the readback word
   // ------------------------------------------------------------------
   // Counter reads are checked for order only
   function automatic logic [31:0] expected_readback(input logic [7:0] a);
      logic [31:0] word;
      word = 32'd0;
      case (a)
         bus_ctrl_pkg::RB_CLK_STATUS:   word = {27'd0, clk_status};
         bus_ctrl_pkg::RB_COMPAT_NUM:   word = 32'h000A_0000;
         bus_ctrl_pkg::RB_SFPP_STATUS0: word = {phy[0], 10'd0, m_chgd[0], pins[0]};
         bus_ctrl_pkg::RB_SFPP_STATUS1: word = {phy[1], 10'd0, m_chgd[1], pins[1]};
         bus_ctrl_pkg::RB_FIFOFLAGS:    word = {{(32 - NUM_FLAGS){1'b0}}, m_fifo_sticky};
         default:                       word = 32'd0;
      endcase
      return word;
   endfunction

   // ------------------------------------------------------------------
   // Host driver
   // ------------------------------------------------------------------
   // Full four-phase cycle with req held extra cycles after ack
   task automatic handshake(input logic wr, input logic [7:0] a,
                            input logic [31:0] d, input int hold);
      int rises_before;
      rises_before = ack_rises;
      @(negedge clk);
      assert (!ack) else stop_with_error("ERROR: o_ack was high before any request");
      req   = 1'b1;
      we    = wr;
      addr  = a;
      wdata = d;
      @(negedge clk);
      while (!ack) @(negedge clk);
      repeat (hold) begin
         @(negedge clk);
         assert (ack) else stop_with_error("ERROR: o_ack dropped while req was still high");
      end
      req = 1'b0;
      @(negedge clk);
      while (ack) @(negedge clk);
      assert (ack_rises == rises_before + 1)
         else stop_with_error("ERROR: o_ack rose more than once for one request");
   endtask

   task automatic write_setting(input logic [7:0] a, input logic [31:0] d);
      handshake(1'b1, a, d, $urandom_range(0, 3));
   endtask

   // Hands the result to the checker and waits until it is compared
   task automatic read_word(input logic [7:0] a);
      handshake(1'b0, a, 32'd0, $urandom_range(0, 3));
      rd_addr = a;
      rd_data = rdata;
      reads_issued = reads_issued + 1;
      wait (reads_checked == reads_issued);
   endtask

   task automatic check_outputs();
      assert (leds == m_leds) else stop_with_error($sformatf(
         "MISMATCH at %0t: o_leds %h, expected %h", $time, leds, m_leds));
      assert (sw_rst == m_sw_rst) else stop_with_error($sformatf(
         "MISMATCH at %0t: o_sw_rst %h, expected %h", $time, sw_rst, m_sw_rst));
      assert (clock_control == m_clock_control) else stop_with_error($sformatf(
         "MISMATCH at %0t: o_clock_control %h, expected %h",
         $time, clock_control, m_clock_control));
      assert (rs_oe0 == m_rs_oe0 && rs_oe1 == m_rs_oe1) else stop_with_error($sformatf(
         "MISMATCH at %0t: rs_oe %h %h, expected %h %h",
         $time, rs_oe0, rs_oe1, m_rs_oe0, m_rs_oe1));
   endtask

   // ------------------------------------------------------------------
   // Read checker
   // ------------------------------------------------------------------
   initial begin : read_checker
      logic [31:0] expected;
      forever begin
         wait (reads_checked != reads_issued);
         if (rd_addr == bus_ctrl_pkg::RB_COUNTER) begin
            assert (rd_data > last_counter) else stop_with_error($sformatf(
               "MISMATCH at %0t: counter read %0d after %0d", $time, rd_data, last_counter));
            last_counter = rd_data;
         end else begin
            expected = expected_readback(rd_addr);
            assert (rd_data == expected) else stop_with_error($sformatf(
               "MISMATCH at %0t: addr %0d read %h, expected %h",
               $time, rd_addr, rd_data, expected));
         end
         reads_checked = reads_checked + 1;
      end
   end

   initial begin : watchdog
      repeat (TOTAL_CYCLES * MARGIN) @(posedge clk);
      stop_with_error("ERROR: watchdog timeout, the tests did not finish in time");
   end

   // ------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------
   initial begin : main_sequence
      logic [31:0] rnd;
      logic [7:0]  a;
      logic [2:0]  flip;
      logic [2:0]  other;
      logic [3:0]  low;
      int          c;
      void'($urandom(3));
      reset      = 1'b1;
      req        = 1'b0;
      we         = 1'b0;
      addr       = 8'd0;
      wdata      = 32'd0;
      pins[0]    = 3'd0;
      pins[1]    = 3'd0;
      phy[0]     = 16'd0;
      phy[1]     = 16'd0;
      m_chgd[0]  = 3'd0;
      m_chgd[1]  = 3'd0;
      clk_status = 5'd0;
      fifo_flags = '1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Reset values and fixed words
      check_outputs();
      read_word(bus_ctrl_pkg::RB_COMPAT_NUM);
      read_word(bus_ctrl_pkg::RB_FIFOFLAGS);
      read_word(bus_ctrl_pkg::RB_SFPP_STATUS0);
      read_word(bus_ctrl_pkg::RB_SFPP_STATUS1);
      for (int i = 1; i < 8; i++) begin
         if (i != 3 && i != 6) read_word(8'(i));
      end

      // Random settings writes including unmapped addresses
      for (int i = 0; i < WRITE_OPS; i++) begin
         rnd = $urandom;
         case ($urandom_range(0, 5))
            0:       a = bus_ctrl_pkg::SR_LEDS;
            1:       a = bus_ctrl_pkg::SR_SW_RST;
            2:       a = bus_ctrl_pkg::SR_CLOCK_CTRL;
            3:       a = bus_ctrl_pkg::SR_SFPP_CTRL0;
            4:       a = bus_ctrl_pkg::SR_SFPP_CTRL1;
            default: a = 8'($urandom_range(11, 255));
         endcase
         write_setting(a, rnd);
         case (a)
            bus_ctrl_pkg::SR_LEDS:       m_leds = rnd[7:0];
            bus_ctrl_pkg::SR_SW_RST:     m_sw_rst = rnd[3:0];
            bus_ctrl_pkg::SR_CLOCK_CTRL: m_clock_control = rnd[6:0];
            bus_ctrl_pkg::SR_SFPP_CTRL0: m_rs_oe0 = rnd[1:0];
            bus_ctrl_pkg::SR_SFPP_CTRL1: m_rs_oe1 = rnd[1:0];
            default: ;
         endcase
         check_outputs();
         read_word(8'($urandom_range(11, 255)));
      end

      // Back-to-back counter reads
      for (int i = 0; i < COUNTER_PAIRS; i++) begin
         read_word(bus_ctrl_pkg::RB_COUNTER);
         read_word(bus_ctrl_pkg::RB_COUNTER);
      end

      for (int i = 0; i < CLK_ROUNDS; i++) begin
         rnd = $urandom;
         clk_status = rnd[4:0];
         read_word(bus_ctrl_pkg::RB_CLK_STATUS);
      end

      // Pin changes, read-clear and isolation between cages
      // Both cages change so a clear of the wrong cage shows up
      for (int i = 0; i < SFP_ROUNDS; i++) begin
         c     = i % 2;
         rnd   = $urandom;
         flip  = rnd[2:0];
         if (flip == 3'd0) flip = 3'b100;
         other = rnd[5:3];
         if (other == 3'd0) other = 3'b001;
         m_chgd[c]     = m_chgd[c] | flip;
         pins[c]       = pins[c] ^ flip;
         phy[c]        = rnd[31:16];
         m_chgd[1 - c] = m_chgd[1 - c] | other;
         pins[1 - c]   = pins[1 - c] ^ other;
         repeat (SETTLE_CYCLES) @(negedge clk);
         read_word(c == 0 ? bus_ctrl_pkg::RB_SFPP_STATUS0 : bus_ctrl_pkg::RB_SFPP_STATUS1);
         m_chgd[c] = 3'd0;
         read_word(c == 0 ? bus_ctrl_pkg::RB_SFPP_STATUS0 : bus_ctrl_pkg::RB_SFPP_STATUS1);
         read_word(c == 0 ? bus_ctrl_pkg::RB_SFPP_STATUS1 : bus_ctrl_pkg::RB_SFPP_STATUS0);
         m_chgd[1 - c] = 3'd0;
      end

      // Sticky FIFO flags cleared every second round
      for (int i = 0; i < FIFO_ROUNDS; i++) begin
         rnd = $urandom;
         low = rnd[3:0];
         if (low == 4'd0) low = 4'b0001;
         fifo_flags    = ~low;
         m_fifo_sticky = m_fifo_sticky | low;
         repeat (2) @(negedge clk);
         fifo_flags = '1;
         repeat (SETTLE_CYCLES) @(negedge clk);
         read_word(bus_ctrl_pkg::RB_FIFOFLAGS);
         if (i % 2 == 1) begin
            write_setting(bus_ctrl_pkg::SR_FIFOFLAGS, rnd);
            m_fifo_sticky = '0;
            read_word(bus_ctrl_pkg::RB_FIFOFLAGS);
         end
      end

      check_outputs();
      if (error_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
bus_ctrl_pkg.sv
host_port.sv
setting_bank.sv
sfp_status_mon.sv
fifo_flag_monitor.sv
readback_mux.sv
bus_ctrl_top.sv
tb_bus_ctrl.sv
